/* compile.f */
+incdir+sim
rtl/dcache_pkg.sv
rtl/dcache_sram.sv
rtl/dcache_port_arb.sv
rtl/dcache_arrays.sv
rtl/dcache_readout.sv
rtl/dcache_mem_top.sv
sim/dcache_mem_tb.sv

/* rtl/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  bank_cmd_t [NUM_BANKS-1:0]             bank_cmd_i,
  input  way_vec_t                              tag_req_i,
  input  logic                                  tag_we_i,
  input  idx_t                                  tag_idx_i,
  input  cl_wr_t                                cl_wr_i,
  input  word_wr_t                              wr_i,
  output word_t     [NUM_BANKS-1:0][NUM_WAYS-1:0] bank_rdata_o,
  output tag_t      [NUM_WAYS-1:0]              tag_rdata_o,
  output way_vec_t                              vld_bits_o
);

  //////////////////////////////////////////////////
  // data banks
  //////////////////////////////////////////////////

  // bank k holds word k of the line for all ways side by side
  // row layout: [way3 | way2 | way1 | way0]
  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    word_t    [NUM_WAYS-1:0] row_wdata;
    word_be_t [NUM_WAYS-1:0] row_be;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
      // line write takes precedence, word write is never acked then
      assign row_wdata[w] = cl_wr_i.vld ? cl_wr_i.data[k*WORD_W +: WORD_W] : wr_i.data;
      // bank we already carries the word write ack
      assign row_be[w]    = cl_wr_i.vld ?
                            (cl_wr_i.we[w] ? cl_wr_i.be[k*(WORD_W/8) +: WORD_W/8] : '0) :
                            (wr_i.req[w]   ? wr_i.be                              : '0);
    end

    dcache_sram #(
      .DATA_W (NUM_WAYS*WORD_W)
    ) u_bank_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_cmd_i[k].req),
      .we_i    (bank_cmd_i[k].we),
      .addr_i  (bank_cmd_i[k].idx),
      .wdata_i (row_wdata),
      .be_i    (row_be),
      .rdata_o (bank_rdata_o[k])
    );
  end

  //////////////////////////////////////////////////
  // tag and valid
  //////////////////////////////////////////////////

  // one RAM per way, entry is {valid, tag}
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_tag
    logic [TAG_W:0] tag_vld_rdata;

    dcache_sram #(
      .DATA_W (TAG_W+1)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req_i[w]),
      .we_i    (tag_we_i),
      .addr_i  (tag_idx_i),
      .wdata_i ({cl_wr_i.vld_bits[w], cl_wr_i.tag}),
      .be_i    ('1),
      .rdata_o (tag_vld_rdata)
    );

    assign tag_rdata_o[w] = tag_vld_rdata[TAG_W-1:0];
    assign vld_bits_o[w]  = tag_vld_rdata[TAG_W];
  end

endmodule

/* rtl/dcache_mem_top.sv */
`timescale 1ns/1ps

module dcache_mem_top import dcache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // read ports, tag follows one cycle after the ack
  input  rd_port_t [NUM_PORTS-1:0]  rd_port_i,
  input  tag_t     [NUM_PORTS-1:0]  rd_tag_i,
  output logic     [NUM_PORTS-1:0]  rd_ack_o,
  output way_vec_t                  rd_vld_bits_o,
  output way_vec_t                  rd_hit_oh_o,
  output word_t                     rd_data_o,
  // line fill
  input  cl_wr_t                    cl_wr_i,
  // word write, no tag access
  input  word_wr_t                  wr_i,
  output logic                      wr_ack_o
);

  bank_cmd_t [NUM_BANKS-1:0]                bank_cmd;
  way_vec_t                                 tag_req;
  logic                                     tag_we;
  idx_t                                     tag_idx;
  lookup_t                                  lookup;
  word_t     [NUM_BANKS-1:0][NUM_WAYS-1:0]  bank_rdata;
  tag_t      [NUM_WAYS-1:0]                 tag_rdata;
  way_vec_t                                 vld_bits;

  // input side, grants and RAM commands
  dcache_port_arb u_port_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_port_i  (rd_port_i),
    .cl_wr_i    (cl_wr_i),
    .wr_i       (wr_i),
    .rd_ack_o   (rd_ack_o),
    .wr_ack_o   (wr_ack_o),
    .bank_cmd_o (bank_cmd),
    .tag_req_o  (tag_req),
    .tag_we_o   (tag_we),
    .tag_idx_o  (tag_idx),
    .lookup_o   (lookup)
  );

  // data banks and tag RAMs
  dcache_arrays u_arrays (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_cmd_i   (bank_cmd),
    .tag_req_i    (tag_req),
    .tag_we_i     (tag_we),
    .tag_idx_i    (tag_idx),
    .cl_wr_i      (cl_wr_i),
    .wr_i         (wr_i),
    .bank_rdata_o (bank_rdata),
    .tag_rdata_o  (tag_rdata),
    .vld_bits_o   (vld_bits)
  );

  // hit detection and read data
  dcache_readout u_readout (
    .lookup_i      (lookup),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .vld_bits_i    (vld_bits),
    .bank_rdata_i  (bank_rdata),
    .cl_wr_i       (cl_wr_i),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  // read ports into the arbiter
  localparam int NUM_PORTS = 3;
  // set associativity
  localparam int NUM_WAYS  = 4;
  // address split: tag | index | byte offset
  localparam int TAG_W     = 8;
  localparam int IDX_W     = 4;
  localparam int OFF_W     = 5;
  // one 64 bit word per bank, four words per line
  localparam int WORD_W    = 64;
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;
  localparam int PORT_W    = 2;

  //////////////////////////////////////////////////
  // plain vector types
  //////////////////////////////////////////////////

  typedef logic [TAG_W-1:0]                  tag_t;
  typedef logic [IDX_W-1:0]                  idx_t;
  typedef logic [OFF_W-1:0]                  off_t;
  // word offset inside a line, upper bits of off_t
  typedef logic [BANK_W-1:0]                 bank_sel_t;
  typedef logic [NUM_WAYS-1:0]               way_vec_t;
  typedef logic [WORD_W-1:0]                 word_t;
  typedef logic [WORD_W/8-1:0]               word_be_t;
  typedef logic [NUM_BANKS*WORD_W-1:0]       line_t;
  typedef logic [NUM_BANKS*WORD_W/8-1:0]     line_be_t;
  typedef logic [PORT_W-1:0]                 port_sel_t;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  // read request, tag_only skips the data banks
  typedef struct packed {
    logic req;
    logic tag_only;
    logic prio;
    idx_t idx;
    off_t off;
  } rd_port_t;

  // full line write, we selects the ways to fill
  typedef struct packed {
    logic     vld;
    way_vec_t we;
    tag_t     tag;
    idx_t     idx;
    off_t     off;
    line_t    data;
    line_be_t be;
    way_vec_t vld_bits;
  } cl_wr_t;

  // single word write, req is one-hot over the ways
  typedef struct packed {
    way_vec_t req;
    idx_t     idx;
    off_t     off;
    word_t    data;
    word_be_t be;
  } word_wr_t;

  // per bank access command
  typedef struct packed {
    logic req;
    logic we;
    idx_t idx;
  } bank_cmd_t;

  // state carried from the grant into the compare cycle
  typedef struct packed {
    logic      cmp_en;
    port_sel_t port_sel;
    bank_sel_t bank_sel;
  } lookup_t;

endpackage

/* rtl/dcache_port_arb.sv */
`timescale 1ns/1ps

module dcache_port_arb import dcache_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rd_port_t  [NUM_PORTS-1:0]     rd_port_i,
  input  cl_wr_t                        cl_wr_i,
  input  word_wr_t                      wr_i,
  output logic      [NUM_PORTS-1:0]     rd_ack_o,
  output logic                          wr_ack_o,
  output bank_cmd_t [NUM_BANKS-1:0]     bank_cmd_o,
  output way_vec_t                      tag_req_o,
  output logic                          tag_we_o,
  output idx_t                          tag_idx_o,
  output lookup_t                       lookup_o
);

  logic [NUM_PORTS-1:0] req_vec;
  logic [NUM_PORTS-1:0] prio_vec;
  logic [NUM_PORTS-1:0] req_masked;
  port_sel_t            rr_ptr_d, rr_ptr_q;
  port_sel_t            gnt_sel;
  logic                 gnt_found;
  logic                 rd_acked;
  logic                 rd_data_req;
  bank_sel_t            rd_bank;
  bank_sel_t            wr_bank;
  logic                 wr_collision;
  lookup_t              lookup_d, lookup_q;

  //////////////////////////////////////////////////
  // read arbitration
  //////////////////////////////////////////////////

  // high prio requests hide all low prio ones
  always_comb begin : p_prio_mask
    for (int p = 0; p < NUM_PORTS; p++) begin
      req_vec[p]  = rd_port_i[p].req;
      prio_vec[p] = rd_port_i[p].req & rd_port_i[p].prio;
    end
    req_masked = (|prio_vec) ? prio_vec : req_vec;
  end

  // round robin search, starting at the pointer
  always_comb begin : p_rr_pick
    int cand;
    gnt_found = 1'b0;
    gnt_sel   = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = int'(rr_ptr_q) + k;
      // wrap, NUM_PORTS is not a power of two
      if (cand >= NUM_PORTS) begin
        cand = cand - NUM_PORTS;
      end
      if (!gnt_found && req_masked[cand]) begin
        gnt_found = 1'b1;
        gnt_sel   = port_sel_t'(cand);
      end
    end
  end

  // a line write owns the tag RAMs, no read gets through
  assign rd_acked = gnt_found & ~cl_wr_i.vld;

  always_comb begin : p_rd_ack
    rd_ack_o = '0;
    if (rd_acked) begin
      rd_ack_o[gnt_sel] = 1'b1;
    end
  end

  // pointer moves one past the winner
  assign rr_ptr_d = (gnt_sel == port_sel_t'(NUM_PORTS-1)) ? '0 : gnt_sel + 1'b1;

  //////////////////////////////////////////////////
  // bank requests and word write grant
  //////////////////////////////////////////////////

  assign rd_bank      = rd_port_i[gnt_sel].off[OFF_W-1 -: BANK_W];
  assign wr_bank      = wr_i.off[OFF_W-1 -: BANK_W];
  // tag only lookups leave the data banks free
  assign rd_data_req  = rd_acked & ~rd_port_i[gnt_sel].tag_only;
  assign wr_collision = rd_data_req & (rd_bank == wr_bank);
  assign wr_ack_o     = (|wr_i.req) & ~cl_wr_i.vld & ~wr_collision;

  always_comb begin : p_bank_cmd
    // idle banks just point at the word write set
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_cmd_o[k].req = 1'b0;
      bank_cmd_o[k].we  = 1'b0;
      bank_cmd_o[k].idx = wr_i.idx;
    end
    if (cl_wr_i.vld) begin
      // full line hits every bank of the set
      for (int k = 0; k < NUM_BANKS; k++) begin
        bank_cmd_o[k].req = 1'b1;
        bank_cmd_o[k].we  = 1'b1;
        bank_cmd_o[k].idx = cl_wr_i.idx;
      end
    end else begin
      if (rd_data_req) begin
        bank_cmd_o[rd_bank].req = 1'b1;
        bank_cmd_o[rd_bank].idx = rd_port_i[gnt_sel].idx;
      end
      // only reached on a different bank than the read
      if (wr_ack_o) begin
        bank_cmd_o[wr_bank].req = 1'b1;
        bank_cmd_o[wr_bank].we  = 1'b1;
        bank_cmd_o[wr_bank].idx = wr_i.idx;
      end
    end
  end

  // tag RAMs: line write picks its ways, a read looks at all
  assign tag_req_o = cl_wr_i.vld ? cl_wr_i.we : {NUM_WAYS{rd_acked}};
  assign tag_we_o  = cl_wr_i.vld;
  assign tag_idx_o = cl_wr_i.vld ? cl_wr_i.idx : rd_port_i[gnt_sel].idx;

  //////////////////////////////////////////////////
  // lookup stage
  //////////////////////////////////////////////////

  // compare only after a tag read that was not a write
  assign lookup_d.cmp_en   = (|tag_req_o) & ~tag_we_o;
  assign lookup_d.port_sel = gnt_sel;
  assign lookup_d.bank_sel = rd_bank;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      lookup_q <= '0;
      rr_ptr_q <= '0;
    end else begin
      lookup_q <= lookup_d;
      if (rd_acked) begin
        rr_ptr_q <= rr_ptr_d;
      end
    end
  end

  assign lookup_o = lookup_q;

endmodule

/* rtl/dcache_readout.sv */
`timescale 1ns/1ps

module dcache_readout import dcache_pkg::*; (
  input  lookup_t                                 lookup_i,
  input  tag_t      [NUM_PORTS-1:0]               rd_tag_i,
  input  tag_t      [NUM_WAYS-1:0]                tag_rdata_i,
  input  way_vec_t                                vld_bits_i,
  input  word_t     [NUM_BANKS-1:0][NUM_WAYS-1:0] bank_rdata_i,
  input  cl_wr_t                                  cl_wr_i,
  output way_vec_t                                rd_hit_oh_o,
  output way_vec_t                                rd_vld_bits_o,
  output word_t                                   rd_data_o
);

  tag_t                 rd_tag;
  word_t [NUM_WAYS-1:0] way_word;
  word_t                hit_word;
  bank_sel_t            cl_bank;

  //////////////////////////////////////////////////
  // tag compare
  //////////////////////////////////////////////////

  // tag comes late, pick it with the registered port
  assign rd_tag = rd_tag_i[lookup_i.port_sel];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = (rd_tag == tag_rdata_i[w]) & vld_bits_i[w] & lookup_i.cmp_en;
    // word of this way from the bank that was read
    assign way_word[w]    = bank_rdata_i[lookup_i.bank_sel][w];
  end

  assign rd_vld_bits_o = vld_bits_i;

  //////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////

  // lowest hitting way wins, way 0 on a miss
  always_comb begin : p_hit_sel
    hit_word = way_word[0];
    for (int w = NUM_WAYS-1; w >= 0; w--) begin
      if (rd_hit_oh_o[w]) begin
        hit_word = way_word[w];
      end
    end
  end

  // line write bypass
  // the written word leaves in the same cycle
  assign cl_bank   = cl_wr_i.off[OFF_W-1 -: BANK_W];
  assign rd_data_o = cl_wr_i.vld ? cl_wr_i.data[cl_bank*WORD_W +: WORD_W] : hit_word;

endmodule

/* rtl/dcache_sram.sv */
`timescale 1ns/1ps

module dcache_sram import dcache_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  idx_t                    addr_i,
  input  logic [DATA_W-1:0]       wdata_i,
  input  logic [(DATA_W+7)/8-1:0] be_i,
  output logic [DATA_W-1:0]       rdata_o
);

  // one row per set
  logic [DATA_W-1:0] mem_q [2**IDX_W];
  logic [DATA_W-1:0] rdata_q;

  // write port
  // byte enables cover the bits of their byte, last byte may be partial
  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      for (int i = 0; i < DATA_W; i++) begin
        if (be_i[i/8]) begin
          mem_q[addr_i][i] <= wdata_i[i];
        end
      end
    end
  end

  // read port, data shows up one cycle after the request
  // a write cycle leaves the old read data in place
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the dcache memory testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module dcache_mem_tb \
  -o dcache_mem_sim

./obj_dir/dcache_mem_sim | tee sim.log

# the testbench prints the pass line only when every check held
if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "no pass line in sim.log"
exit 1

/* sim/dcache_mem_model.svh */
`ifndef DCACHE_MEM_MODEL_SVH
`define DCACHE_MEM_MODEL_SVH

//////////////////////////////////////////////////
// reference state of tags, valid bits and lines
//////////////////////////////////////////////////

localparam int NUM_SETS = 2**IDX_W;

tag_t  m_tag  [NUM_SETS][NUM_WAYS];
logic  m_vld  [NUM_SETS][NUM_WAYS];
line_t m_data [NUM_SETS][NUM_WAYS];
int    n_checks = 0;
int    n_errors = 0;

// line fill, only ways in we change, data bytes follow be
function automatic void model_line_write(input cl_wr_t cl);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (cl.we[w]) begin
      m_tag[cl.idx][w] = cl.tag;
      m_vld[cl.idx][w] = cl.vld_bits[w];
      for (int b = 0; b < NUM_BANKS*WORD_W/8; b++) begin
        if (cl.be[b]) begin
          m_data[cl.idx][w][b*8 +: 8] = cl.data[b*8 +: 8];
        end
      end
    end
  end
endfunction

// acked word write, bytes merge into one word of the line
function automatic void model_word_write(input word_wr_t ww);
  int base;
  base = int'(ww.off[OFF_W-1 -: BANK_W]) * WORD_W;
  for (int w = 0; w < NUM_WAYS; w++) begin
    for (int b = 0; b < WORD_W/8; b++) begin
      if (ww.req[w] && ww.be[b]) begin
        m_data[ww.idx][w][base + b*8 +: 8] = ww.data[b*8 +: 8];
      end
    end
  end
endfunction

function automatic way_vec_t model_hit(input idx_t idx, input tag_t tag);
  way_vec_t hit;
  for (int w = 0; w < NUM_WAYS; w++) begin
    hit[w] = m_vld[idx][w] && (m_tag[idx][w] == tag);
  end
  return hit;
endfunction

function automatic way_vec_t model_vld(input idx_t idx);
  way_vec_t vld;
  for (int w = 0; w < NUM_WAYS; w++) begin
    vld[w] = m_vld[idx][w];
  end
  return vld;
endfunction

// lowest hitting way supplies the word
function automatic word_t model_word(input idx_t idx, input way_vec_t hit, input bank_sel_t bank);
  word_t word;
  word = '0;
  for (int w = NUM_WAYS-1; w >= 0; w--) begin
    if (hit[w]) begin
      word = m_data[idx][w][int'(bank)*WORD_W +: WORD_W];
    end
  end
  return word;
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_way_vec(input string name, input way_vec_t got, input way_vec_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_ack(input string name, input logic [NUM_PORTS-1:0] got,
                         input logic [NUM_PORTS-1:0] exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

`endif

/* sim/dcache_mem_tb.sv */
`timescale 1ns/1ps

module dcache_mem_tb import dcache_pkg::*; ();

  logic                     clk;
  logic                     rst_n;
  rd_port_t [NUM_PORTS-1:0] rd_port;
  tag_t     [NUM_PORTS-1:0] rd_tag;
  cl_wr_t                   cl_wr;
  word_wr_t                 wr;
  logic     [NUM_PORTS-1:0] rd_ack;
  logic                     wr_ack;
  way_vec_t                 rd_vld_bits;
  way_vec_t                 rd_hit_oh;
  word_t                    rd_data;

  `include "dcache_mem_model.svh"

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 5;
  localparam int N_MISS      = 40;
  localparam int N_FILL      = 40;
  localparam int N_ARB       = 200;
  localparam int N_WW        = 200;
  localparam int N_TO        = 60;
  // one flush cycle per test
  localparam int TEST_CYCLES = NUM_SETS + N_MISS + 3*N_FILL + N_ARB + N_WW + N_TO + 5;
  localparam int WATCHDOG_NS = (RST_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

  integer    seed = 32'h096d302e;
  // expected round robin pointer and the read waiting for its lookup
  port_sel_t rr_ptr;
  logic      pend_vld;
  port_sel_t pend_port;
  idx_t      pend_idx;
  tag_t      pend_tag;
  logic      pend_tag_only;
  bank_sel_t pend_bank;

  dcache_mem_top u_dcache_mem_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rd_port_i     (rd_port),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_data_o     (rd_data),
    .cl_wr_i       (cl_wr),
    .wr_i          (wr),
    .wr_ack_o      (wr_ack)
  );

  initial begin : clk_gen
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("error: watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // random stimulus helpers
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < NUM_BANKS*WORD_W/32; i++) begin
      l[i*32 +: 32] = $random(seed);
    end
    return l;
  endfunction

  // mostly a tag already held in the set so reads tend to hit
  function automatic tag_t pick_tag(input idx_t idx);
    if (rand_below(4) != 0) begin
      return m_tag[idx][rand_below(NUM_WAYS)];
    end
    return tag_t'($random(seed));
  endfunction

  function automatic rd_port_t rand_rd(input idx_t idx, input logic prio, input logic tag_only);
    rd_port_t r;
    r.req      = 1'b1;
    r.tag_only = tag_only;
    r.prio     = prio;
    r.idx      = idx;
    r.off      = off_t'($random(seed));
    return r;
  endfunction

  function automatic cl_wr_t rand_fill(input idx_t idx, input way_vec_t we);
    cl_wr_t c;
    c.vld      = 1'b1;
    c.we       = we;
    c.tag      = tag_t'($random(seed));
    c.idx      = idx;
    c.off      = off_t'($random(seed));
    c.data     = rand_line();
    c.be       = line_be_t'($random(seed));
    c.vld_bits = way_vec_t'($random(seed));
    return c;
  endfunction

  // word write on one random way
  function automatic word_wr_t rand_wr(input idx_t idx);
    word_wr_t w;
    w.req  = way_vec_t'(1 << rand_below(NUM_WAYS));
    w.idx  = idx;
    w.off  = off_t'($random(seed));
    w.data = {$random(seed), $random(seed)};
    w.be   = word_be_t'($random(seed));
    return w;
  endfunction

  //////////////////////////////////////////////////
  // one clock cycle with all checks
  //////////////////////////////////////////////////

  task automatic step(input rd_port_t [NUM_PORTS-1:0] rp, input tag_t [NUM_PORTS-1:0] want,
                      input cl_wr_t cl, input word_wr_t ww);
    logic                 any_prio;
    logic                 found;
    port_sel_t            gnt;
    int                   cand;
    logic [NUM_PORTS-1:0] exp_ack;
    logic                 exp_wack;
    way_vec_t             exp_hit;
    bank_sel_t            cl_bank;
    @(posedge clk);
    rd_port <= rp;
    cl_wr   <= cl;
    wr      <= ww;
    // tag of last cycle's granted read, noise on the other ports
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (pend_vld && pend_port == port_sel_t'(q)) begin
        rd_tag[q] <= pend_tag;
      end else begin
        rd_tag[q] <= tag_t'($random(seed));
      end
    end
    @(negedge clk);
    // lookup of the previous read, zero hits when there was none
    exp_hit = pend_vld ? model_hit(pend_idx, pend_tag) : '0;
    check_way_vec("rd_hit_oh_o", rd_hit_oh, exp_hit);
    if (pend_vld) begin
      check_way_vec("rd_vld_bits_o", rd_vld_bits, model_vld(pend_idx));
    end
    cl_bank = cl.off[OFF_W-1 -: BANK_W];
    if (cl.vld) begin
      // line write word bypassed in the same cycle
      check_word("rd_data_o", rd_data, cl.data[int'(cl_bank)*WORD_W +: WORD_W]);
    end else if (pend_vld && !pend_tag_only && exp_hit != '0) begin
      check_word("rd_data_o", rd_data, model_word(pend_idx, exp_hit, pend_bank));
    end
    // high prio requests mask the rest, then round robin from the pointer
    any_prio = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      any_prio = any_prio | (rp[q].req & rp[q].prio);
    end
    found = 1'b0;
    gnt   = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = (int'(rr_ptr) + k) % NUM_PORTS;
      if (!found && rp[cand].req && (rp[cand].prio || !any_prio)) begin
        found = 1'b1;
        gnt   = port_sel_t'(cand);
      end
    end
    exp_ack = '0;
    if (found && !cl.vld) begin
      exp_ack[gnt] = 1'b1;
    end
    check_ack("rd_ack_o", rd_ack, exp_ack);
    // word write loses only to a data read of its bank or a line write
    exp_wack = (ww.req != '0) && !cl.vld;
    if (exp_ack != '0 && !rp[gnt].tag_only &&
        rp[gnt].off[OFF_W-1 -: BANK_W] == ww.off[OFF_W-1 -: BANK_W]) begin
      exp_wack = 1'b0;
    end
    check_bit("wr_ack_o", wr_ack, exp_wack);
    // reference state moves past this cycle
    pend_vld      = (exp_ack != '0);
    pend_port     = gnt;
    pend_idx      = rp[gnt].idx;
    pend_tag      = want[gnt];
    pend_tag_only = rp[gnt].tag_only;
    pend_bank     = rp[gnt].off[OFF_W-1 -: BANK_W];
    if (pend_vld) begin
      rr_ptr = (int'(gnt) == NUM_PORTS-1) ? '0 : port_sel_t'(int'(gnt) + 1);
    end
    if (cl.vld) begin
      model_line_write(cl);
    end
    if (exp_wack) begin
      model_word_write(ww);
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("[%s] %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_invalidate();
    rd_port_t [NUM_PORTS-1:0] rp;
    tag_t     [NUM_PORTS-1:0] want;
    cl_wr_t                   cl;
    int                       c0;
    int                       e0;
    int                       p;
    c0 = n_checks;
    e0 = n_errors;
    // every way gets known data and a cleared valid bit
    for (int s = 0; s < NUM_SETS; s++) begin
      cl          = rand_fill(idx_t'(s), '1);
      cl.be       = '1;
      cl.vld_bits = '0;
      step('0, '0, cl, '0);
    end
    for (int i = 0; i < N_MISS; i++) begin
      rp      = '0;
      want    = '0;
      p       = rand_below(NUM_PORTS);
      rp[p]   = rand_rd(idx_t'($random(seed)), rand_below(2) == 1, 1'b0);
      want[p] = tag_t'($random(seed));
      step(rp, want, '0, '0);
    end
    step('0, '0, '0, '0);
    report_test("invalidate", c0, e0);
  endtask

  task automatic test_line_hit();
    rd_port_t [NUM_PORTS-1:0] rp;
    tag_t     [NUM_PORTS-1:0] want;
    cl_wr_t                   cl;
    idx_t                     s;
    int                       c0;
    int                       e0;
    int                       p;
    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < N_FILL; i++) begin
      s           = idx_t'($random(seed));
      cl          = rand_fill(s, way_vec_t'(1 << rand_below(NUM_WAYS)));
      cl.vld_bits = '1;
      if (rand_below(2) == 0) begin
        cl.be = '1;
      end
      step('0, '0, cl, '0);
      // read back with the fill tag, idle cycle keeps rd_data_o visible
      rp      = '0;
      want    = '0;
      p       = rand_below(NUM_PORTS);
      rp[p]   = rand_rd(s, rand_below(2) == 1, 1'b0);
      want[p] = cl.tag;
      step(rp, want, '0, '0);
      step('0, '0, '0, '0);
    end
    report_test("line_hit", c0, e0);
  endtask

  task automatic test_arb();
    rd_port_t [NUM_PORTS-1:0] rp;
    tag_t     [NUM_PORTS-1:0] want;
    cl_wr_t                   cl;
    int                       c0;
    int                       e0;
    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < N_ARB; i++) begin
      rp   = '0;
      want = '0;
      cl   = '0;
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (rand_below(4) != 0) begin
          rp[q]   = rand_rd(idx_t'($random(seed)), rand_below(2) == 1, rand_below(4) == 0);
          want[q] = pick_tag(rp[q].idx);
        end
      end
      // occasional line write blocks all reads
      if (rand_below(8) == 0) begin
        cl     = rand_fill(idx_t'($random(seed)), way_vec_t'($random(seed)));
        cl.tag = pick_tag(cl.idx);
      end
      step(rp, want, cl, '0);
    end
    step('0, '0, '0, '0);
    report_test("arbitration", c0, e0);
  endtask

  task automatic test_word_write();
    rd_port_t [NUM_PORTS-1:0] rp;
    tag_t     [NUM_PORTS-1:0] want;
    cl_wr_t                   cl;
    word_wr_t                 ww;
    int                       c0;
    int                       e0;
    c0 = n_checks;
    e0 = n_errors;
    // few sets so written bytes come back in later reads
    for (int i = 0; i < N_WW; i++) begin
      rp   = '0;
      want = '0;
      cl   = '0;
      ww   = '0;
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (rand_below(2) == 0) begin
          rp[q]   = rand_rd(idx_t'(rand_below(4)), rand_below(2) == 1, rand_below(4) == 0);
          want[q] = pick_tag(rp[q].idx);
        end
      end
      if (rand_below(4) != 0) begin
        ww = rand_wr(idx_t'(rand_below(4)));
      end
      if (rand_below(10) == 0) begin
        cl     = rand_fill(idx_t'(rand_below(4)), way_vec_t'($random(seed)));
        cl.tag = pick_tag(cl.idx);
      end
      step(rp, want, cl, ww);
    end
    step('0, '0, '0, '0);
    report_test("word_write", c0, e0);
  endtask

  task automatic test_tag_only();
    rd_port_t [NUM_PORTS-1:0] rp;
    tag_t     [NUM_PORTS-1:0] want;
    word_wr_t                 ww;
    int                       c0;
    int                       e0;
    int                       p;
    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < N_TO; i++) begin
      rp      = '0;
      want    = '0;
      p       = rand_below(NUM_PORTS);
      rp[p]   = rand_rd(idx_t'($random(seed)), rand_below(2) == 1, 1'b1);
      want[p] = pick_tag(rp[p].idx);
      // same bank as the lookup, still acked
      ww = rand_wr(idx_t'($random(seed)));
      ww.off[OFF_W-1 -: BANK_W] = rp[p].off[OFF_W-1 -: BANK_W];
      step(rp, want, '0, ww);
    end
    step('0, '0, '0, '0);
    report_test("tag_only", c0, e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : main
    rst_n         = 1'b0;
    rd_port       = '0;
    rd_tag        = '0;
    cl_wr         = '0;
    wr            = '0;
    rr_ptr        = '0;
    pend_vld      = 1'b0;
    pend_port     = '0;
    pend_idx      = '0;
    pend_tag      = '0;
    pend_tag_only = 1'b0;
    pend_bank     = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // lookup registers leave reset cleared
    check_way_vec("rd_hit_oh_o", rd_hit_oh, '0);
    test_invalidate();
    test_line_hit();
    test_arb();
    test_word_write();
    test_tag_only();
    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
